/* hw/bus_pkg.sv */
//**********************************************************************
// bus_pkg: address layouts, size codes and region constants of the
// board bus
//**********************************************************************
`default_nettype none

package bus_pkg;

  // transfer size on the bus
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // memory map
  localparam logic [5:0] REGION_RAM = 6'd0;
  localparam logic [3:0] SPACE_IO   = 4'd3;
  localparam logic [7:0] DEV_TMR    = 8'h00;
  localparam logic [7:0] DEV_BIO    = 8'h10;

  typedef struct packed {
    logic [5:0]  region;
    logic [25:0] offset;
  } mem_view_t;

  typedef struct packed {
    logic [3:0]  space;
    logic [7:0]  dev;
    logic [7:0]  unit_id;
    logic [11:0] reg_off;
  } io_view_t;

  // one address word, seen as memory or as i/o space
  typedef union packed {
    mem_view_t mem;
    io_view_t  io;
  } bus_addr_u;

endpackage

`default_nettype wire

/* hw/bus_if.sv */
//**********************************************************************
// bus_if: slave side of the board bus, one per slave
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

interface bus_if #(
  parameter int DW = 32
);
  logic          en;
  logic          wr;
  logic [1:0]    size;
  logic [23:0]   addr;
  logic [DW-1:0] wdata;
  logic [DW-1:0] rdata;
  logic          wt;

  modport master  (output en, wr, size, addr, wdata, input rdata, wt);
  modport slave   (input en, wr, size, addr, wdata, output rdata, wt);
  modport monitor (input en, wr, size, addr, wdata, rdata, wt);
endinterface

`default_nettype wire

/* hw/bus_decode.sv */
//**********************************************************************
// bus_decode: splits the cpu address, selects one slave and fans the
// request out to it
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  wire logic        i_cpu_en,
  input  wire logic        i_cpu_wr,
  input  wire logic [1:0]  i_cpu_size,
  input  wire logic [31:0] i_cpu_addr,
  input  wire logic [31:0] i_cpu_wdata,
  output logic [3:0]       o_sel,
  bus_if.master            ram_bus,
  bus_if.master            tmr0_bus,
  bus_if.master            tmr1_bus,
  bus_if.master            bio_bus
);
  import bus_pkg::*;

  bus_addr_u a;
  logic      io_hit;
  logic      tmr_dev_hit;

  assign a = i_cpu_addr;

  // ram takes the lowest 64 MB, i/o sits at 0x3xxx_xxxx
  assign io_hit      = (a.io.space == SPACE_IO);
  assign tmr_dev_hit = io_hit && (a.io.dev == DEV_TMR);

  // bit 0 ram, 1 timer 0, 2 timer 1, 3 board i/o
  assign o_sel[0] = (a.mem.region == REGION_RAM);
  assign o_sel[1] = tmr_dev_hit && (a.io.unit_id == 8'h00);
  assign o_sel[2] = tmr_dev_hit && (a.io.unit_id == 8'h01);
  assign o_sel[3] = io_hit && (a.io.dev == DEV_BIO) && (a.io.unit_id == 8'h00);

  assign ram_bus.en    = i_cpu_en && o_sel[0];
  assign ram_bus.wr    = i_cpu_wr;
  assign ram_bus.size  = i_cpu_size;
  assign ram_bus.addr  = a.mem.offset[23:0];
  assign ram_bus.wdata = i_cpu_wdata;

  assign tmr0_bus.en    = i_cpu_en && o_sel[1];
  assign tmr0_bus.wr    = i_cpu_wr;
  assign tmr0_bus.size  = i_cpu_size;
  assign tmr0_bus.addr  = a.mem.offset[23:0];
  assign tmr0_bus.wdata = i_cpu_wdata;

  assign tmr1_bus.en    = i_cpu_en && o_sel[2];
  assign tmr1_bus.wr    = i_cpu_wr;
  assign tmr1_bus.size  = i_cpu_size;
  assign tmr1_bus.addr  = a.mem.offset[23:0];
  assign tmr1_bus.wdata = i_cpu_wdata;

  // board i/o only sees the low 16 data lanes
  assign bio_bus.en    = i_cpu_en && o_sel[3];
  assign bio_bus.wr    = i_cpu_wr;
  assign bio_bus.size  = i_cpu_size;
  assign bio_bus.addr  = a.mem.offset[23:0];
  assign bio_bus.wdata = i_cpu_wdata[15:0];

endmodule

`default_nettype wire

/* hw/ram_dev.sv */
//**********************************************************************
// ram_dev: big-endian word ram with byte and halfword access
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_dev #(
  parameter int RAM_AW = 10
) (
  input wire logic i_clk,
  input wire logic i_rst,
  bus_if.slave     s
);
  import bus_pkg::*;

  logic [31:0]       mem [0:(2**RAM_AW)-1];
  logic [RAM_AW-1:0] widx;
  logic [1:0]        lane;
  logic [31:0]       word;
  logic              rd_wait;

  // higher offsets alias onto the same words
  assign widx = s.addr[RAM_AW+1:2];
  assign lane = s.addr[1:0];
  assign word = mem[widx];

  // lane 0 is the most significant byte
  always_ff @(posedge i_clk) begin
    if (s.en && s.wr) begin
      case (s.size)
        SIZE_BYTE: mem[widx][8*(3-lane) +: 8] <= s.wdata[7:0];
        SIZE_HALF: mem[widx][16*(1-lane[1]) +: 16] <= s.wdata[15:0];
        SIZE_WORD: mem[widx] <= s.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (s.size)
      SIZE_BYTE: s.rdata = {24'h0, word[8*(3-lane) +: 8]};
      SIZE_HALF: s.rdata = {16'h0, word[16*(1-lane[1]) +: 16]};
      SIZE_WORD: s.rdata = word;
      default:   s.rdata = word;
    endcase
  end

  // reads wait one cycle, set in the first and dropped after the second
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= s.en && !s.wr && !rd_wait;
    end
  end

  assign s.wt = s.en && !s.wr && !rd_wait;

endmodule

`default_nettype wire

/* hw/tmr_dev.sv */
//**********************************************************************
// tmr_dev: down-counting interval timer with expiry flag and interrupt
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tmr_dev (
  input  wire logic i_clk,
  input  wire logic i_rst,
  bus_if.slave      s,
  output logic      o_irq
);
  logic [31:0] divisor;
  logic [31:0] counter;
  logic        expired;
  logic        irq_en;
  logic        wr_ctl;
  logic        wr_div;

  // reg 0 control, 1 divisor, 2 counter
  assign wr_ctl = s.en && s.wr && (s.addr[3:2] == 2'd0);
  assign wr_div = s.en && s.wr && (s.addr[3:2] == 2'd1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      divisor <= 32'h0;
      counter <= 32'h0;
      expired <= 1'b0;
      irq_en  <= 1'b0;
    end else begin
      if (wr_div) begin
        divisor <= s.wdata;
        counter <= s.wdata;
      end else if (divisor != 32'h0) begin
        if (counter == 32'h1) begin
          counter <= divisor;
          expired <= 1'b1;
        end else begin
          counter <= counter - 32'h1;
        end
      end
      // a control write wins over an expiry in the same cycle
      if (wr_ctl) begin
        irq_en  <= s.wdata[1];
        expired <= 1'b0;
      end
    end
  end

  always_comb begin
    case (s.addr[3:2])
      2'd0:    s.rdata = {30'h0, irq_en, expired};
      2'd1:    s.rdata = divisor;
      2'd2:    s.rdata = counter;
      default: s.rdata = 32'h0;
    endcase
  end

  assign s.wt  = 1'b0;
  assign o_irq = expired && irq_en;

endmodule

`default_nettype wire

/* hw/bio_dev.sv */
//**********************************************************************
// bio_dev: board i/o with led register and switch sampler
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bio_dev #(
  parameter int NUM_LED = 8,
  parameter int NUM_SW  = 8
) (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  bus_if.slave                   s,
  input  wire logic [NUM_SW-1:0] i_sw,
  output logic [NUM_LED-1:0]     o_led
);
  logic [NUM_SW-1:0] sw_meta;
  logic [NUM_SW-1:0] sw_sync;

  // switches are asynchronous to the bus clock
  always_ff @(posedge i_clk) begin
    sw_meta <= i_sw;
    sw_sync <= sw_meta;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_led <= '0;
    end else if (s.en && s.wr && !s.addr[2]) begin
      o_led <= s.wdata[NUM_LED-1:0];
    end
  end

  always_comb begin
    s.rdata = '0;
    if (s.addr[2]) begin
      s.rdata[NUM_SW-1:0] = sw_sync;
    end else begin
      s.rdata[NUM_LED-1:0] = o_led;
    end
  end

  assign s.wt = 1'b0;

endmodule

`default_nettype wire

/* hw/bus_result.sv */
//**********************************************************************
// bus_result: returns read data and wait level of the selected slave
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bus_result (
  input  wire logic [3:0] i_sel,
  bus_if.monitor          ram_bus,
  bus_if.monitor          tmr0_bus,
  bus_if.monitor          tmr1_bus,
  bus_if.monitor          bio_bus,
  output logic [31:0]     o_cpu_rdata,
  output logic            o_cpu_wt
);

  always_comb begin
    case (i_sel)
      4'b0001: begin
        o_cpu_rdata = ram_bus.rdata;
        o_cpu_wt    = ram_bus.wt;
      end
      4'b0010: begin
        o_cpu_rdata = tmr0_bus.rdata;
        o_cpu_wt    = tmr0_bus.wt;
      end
      4'b0100: begin
        o_cpu_rdata = tmr1_bus.rdata;
        o_cpu_wt    = tmr1_bus.wt;
      end
      4'b1000: begin
        o_cpu_rdata = {16'h0, bio_bus.rdata};
        o_cpu_wt    = bio_bus.wt;
      end
      // nothing mapped here, so the access never completes
      default: begin
        o_cpu_rdata = 32'h0;
        o_cpu_wt    = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/bus_top.sv */
//**********************************************************************
// bus_top: board bus with decode, ram, two timers, board i/o and the
// result path
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
  parameter int RAM_AW  = 10,
  parameter int NUM_LED = 8,
  parameter int NUM_SW  = 8
) (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_cpu_en,
  input  wire logic              i_cpu_wr,
  input  wire logic [1:0]        i_cpu_size,
  input  wire logic [31:0]       i_cpu_addr,
  input  wire logic [31:0]       i_cpu_wdata,
  output logic [31:0]            o_cpu_rdata,
  output logic                   o_cpu_wt,
  output logic [1:0]             o_tmr_irq,
  input  wire logic [NUM_SW-1:0] i_sw,
  output logic [NUM_LED-1:0]     o_led
);
  logic [3:0] sel;

  bus_if #(.DW(32)) ram_bus ();
  bus_if #(.DW(32)) tmr0_bus ();
  bus_if #(.DW(32)) tmr1_bus ();
  bus_if #(.DW(16)) bio_bus ();

  bus_decode u_decode (
    .i_cpu_en    (i_cpu_en),
    .i_cpu_wr    (i_cpu_wr),
    .i_cpu_size  (i_cpu_size),
    .i_cpu_addr  (i_cpu_addr),
    .i_cpu_wdata (i_cpu_wdata),
    .o_sel       (sel),
    .ram_bus     (ram_bus.master),
    .tmr0_bus    (tmr0_bus.master),
    .tmr1_bus    (tmr1_bus.master),
    .bio_bus     (bio_bus.master)
  );

  ram_dev #(.RAM_AW(RAM_AW)) u_ram (.i_clk(i_clk), .i_rst(i_rst), .s(ram_bus.slave));

  tmr_dev u_tmr0 (.i_clk(i_clk), .i_rst(i_rst), .s(tmr0_bus.slave), .o_irq(o_tmr_irq[0]));
  tmr_dev u_tmr1 (.i_clk(i_clk), .i_rst(i_rst), .s(tmr1_bus.slave), .o_irq(o_tmr_irq[1]));

  bio_dev #(.NUM_LED(NUM_LED), .NUM_SW(NUM_SW)) u_bio (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .s     (bio_bus.slave),
    .i_sw  (i_sw),
    .o_led (o_led)
  );

  bus_result u_result (
    .i_sel       (sel),
    .ram_bus     (ram_bus.monitor),
    .tmr0_bus    (tmr0_bus.monitor),
    .tmr1_bus    (tmr1_bus.monitor),
    .bio_bus     (bio_bus.monitor),
    .o_cpu_rdata (o_cpu_rdata),
    .o_cpu_wt    (o_cpu_wt)
  );

endmodule

`default_nettype wire

/* dv/tb_clk.sv */
//**********************************************************************
// tb_clk: testbench clock and reset generator
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
  parameter int HALF_NS    = 10,
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  // reset drops on a rising edge, after RST_CYCLES of them
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* dv/bus_checker.sv */
//**********************************************************************
// bus_checker: protocol assertions on the board bus, bound into bus_top
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module bus_checker (
  input wire logic       i_clk,
  input wire logic       i_rst,
  input wire logic       i_en,
  input wire logic       i_wr,
  input wire logic [3:0] i_sel,
  input wire logic       i_wt,
  input wire logic [1:0] i_irq,
  input wire logic       i_irq_en0,
  input wire logic       i_irq_en1
);
  int   fail_cnt = 0;
  logic ram_rd;

  assign ram_rd = i_en && !i_wr && i_sel[0];

  a_sel_onehot: assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(i_sel))
    else begin
      fail_cnt++;
      $error("decode select is not one-hot");
    end

  a_unmapped_wt: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_en && (i_sel == 4'b0000)) |-> i_wt)
    else begin
      fail_cnt++;
      $error("unmapped access released its wait level");
    end

  // first read cycle waits, the one after it completes
  a_ram_rd_first: assert property (@(posedge i_clk) disable iff (i_rst) $rose(ram_rd) |-> i_wt)
    else begin
      fail_cnt++;
      $error("ram read completed in its first cycle");
    end

  a_ram_rd_second: assert property (@(posedge i_clk) disable iff (i_rst)
    (ram_rd && i_wt) |=> !i_wt)
    else begin
      fail_cnt++;
      $error("ram read still waiting in its second cycle");
    end

  a_irq_gated: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_irq & ~{i_irq_en1, i_irq_en0}) == 2'b00)
    else begin
      fail_cnt++;
      $error("timer interrupt raised with its enable clear");
    end

endmodule

bind bus_top bus_checker u_chk (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_en      (i_cpu_en),
  .i_wr      (i_cpu_wr),
  .i_sel     (sel),
  .i_wt      (o_cpu_wt),
  .i_irq     (o_tmr_irq),
  .i_irq_en0 (u_tmr0.irq_en),
  .i_irq_en1 (u_tmr1.irq_en)
);

`default_nettype wire

/* dv/tb_monitor.sv */
//**********************************************************************
// tb_monitor: compares completed bus reads with the expected values
// and keeps the per-test and total counts
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_monitor (
  input wire logic        i_clk,
  input wire logic        i_rst,
  input wire logic        i_en,
  input wire logic        i_wt,
  input wire logic        i_chk,
  input wire logic [31:0] i_exp,
  input wire logic [31:0] i_rdata
);
  int n_test   = 0;
  int n_chk    = 0;
  int n_err    = 0;
  int test_chk = 0;
  int test_err = 0;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    test_chk++;
    if (act !== exp) begin
      test_err++;
      $display("ERR %0t %s exp %08h got %08h", $time, name, exp, act);
    end
  endtask

  task automatic note_fail(input string msg);
    test_chk++;
    test_err++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    $display("test %-9s %0d checks, %0d errors", name, test_chk, test_err);
    n_test++;
    n_chk    += test_chk;
    n_err    += test_err;
    test_chk = 0;
    test_err = 0;
  endtask

  task automatic summary(input int n_assert);
    n_chk += test_chk;
    n_err += test_err;
    $display("totals: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             n_test, n_chk, n_err, n_assert);
  endtask

  // an access completes on a rising edge with wt low
  always @(posedge i_clk) begin
    if (!i_rst && i_en && !i_wt && i_chk) begin
      compare("o_cpu_rdata", i_exp, i_rdata);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
//**********************************************************************
// tb_top: random bus traffic against a reference model of ram, timers
// and board i/o
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import bus_pkg::*;

  localparam int RAM_AW  = 10;
  localparam int NUM_LED = 8;
  localparam int NUM_SW  = 8;
  localparam int TIMEOUT = 50;
  // offset bits that only alias inside the 64 MB ram window
  localparam logic [31:0] ALIAS_BITS = 32'h03FF_FFFF & ~((32'h1 << (RAM_AW + 2)) - 32'h1);
  localparam logic [31:0] TMR_BASE   = 32'h3000_0000;
  localparam logic [31:0] BIO_BASE   = 32'h3100_0000;

  logic               clk;
  logic               rst;
  logic               cpu_en;
  logic               cpu_wr;
  logic [1:0]         cpu_size;
  logic [31:0]        cpu_addr;
  logic [31:0]        cpu_wdata;
  logic [31:0]        cpu_rdata;
  logic               cpu_wt;
  logic [1:0]         tmr_irq;
  logic [NUM_SW-1:0]  sw;
  logic [NUM_LED-1:0] led;
  logic               chk;
  logic [31:0]        exp_rdata;
  logic [31:0]        seed = 32'd60;
  logic [31:0]        ram_m [0:(2**RAM_AW)-1];

  tb_clk u_clk (.o_clk(clk), .o_rst(rst));

  bus_top #(.RAM_AW(RAM_AW), .NUM_LED(NUM_LED), .NUM_SW(NUM_SW)) i_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_cpu_en    (cpu_en),
    .i_cpu_wr    (cpu_wr),
    .i_cpu_size  (cpu_size),
    .i_cpu_addr  (cpu_addr),
    .i_cpu_wdata (cpu_wdata),
    .o_cpu_rdata (cpu_rdata),
    .o_cpu_wt    (cpu_wt),
    .o_tmr_irq   (tmr_irq),
    .i_sw        (sw),
    .o_led       (led)
  );

  tb_monitor u_mon (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_en    (cpu_en),
    .i_wt    (cpu_wt),
    .i_chk   (chk),
    .i_exp   (exp_rdata),
    .i_rdata (cpu_rdata)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % (32'h1 << RAM_AW));
  endfunction

  // big-endian lanes, byte 0 is the top of the word
  function automatic void lane_of(input logic [1:0] size, input logic [31:0] addr,
                                  output logic [31:0] mask, output int sh);
    if (size == SIZE_BYTE) begin
      mask = 32'hFF;
      sh   = 24 - 8 * int'(addr[1:0]);
    end else if (size == SIZE_HALF) begin
      mask = 32'hFFFF;
      sh   = addr[1] ? 0 : 16;
    end else begin
      mask = 32'hFFFF_FFFF;
      sh   = 0;
    end
  endfunction

  function automatic logic [31:0] ram_load(input logic [1:0] size, input logic [31:0] addr);
    logic [31:0] mask;
    int          sh;
    lane_of(size, addr, mask, sh);
    return (ram_m[word_index(addr)] >> sh) & mask;
  endfunction

  function automatic void ram_store(input logic [1:0] size, input logic [31:0] addr,
                                    input logic [31:0] data);
    logic [31:0] mask;
    int          sh;
    int          idx;
    lane_of(size, addr, mask, sh);
    idx        = word_index(addr);
    ram_m[idx] = (ram_m[idx] & ~(mask << sh)) | ((data & mask) << sh);
  endfunction

  task automatic abort_run(input string msg);
    u_mon.note_fail(msg);
    u_mon.summary(i_dut.u_chk.fail_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      cpu_en = 1'b0;
      chk    = 1'b0;
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      abort_run("reset was never released");
    end
  endtask

  // drives one access and waits for the completing edge
  task automatic bus_access(input logic wr, input logic [1:0] size, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp);
    int n;
    @(negedge clk);
    cpu_en    = 1'b1;
    cpu_wr    = wr;
    cpu_size  = size;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    chk       = !wr;
    exp_rdata = exp;
    n         = 0;
    @(posedge clk);
    while (cpu_wt && n < TIMEOUT) begin
      n++;
      @(posedge clk);
    end
    if (cpu_wt) begin
      abort_run($sformatf("access to %08h got no wait release within %0d cycles",
                          addr, TIMEOUT));
    end
  endtask

  task automatic bus_write(input logic [1:0] size, input logic [31:0] addr,
                           input logic [31:0] data);
    bus_access(1'b1, size, addr, data, 32'h0);
  endtask

  task automatic bus_read(input logic [1:0] size, input logic [31:0] addr,
                          input logic [31:0] exp);
    bus_access(1'b0, size, addr, 32'h0, exp);
  endtask

  task automatic check_irq(input logic [1:0] exp);
    idle(1);
    u_mon.compare("o_tmr_irq", {30'h0, exp}, {30'h0, tmr_irq});
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] base;
    logic [1:0]  sz;
    cpu_en    = 1'b0;
    cpu_wr    = 1'b0;
    cpu_size  = SIZE_WORD;
    cpu_addr  = 32'h0;
    cpu_wdata = 32'h0;
    sw        = '0;
    chk       = 1'b0;
    exp_rdata = 32'h0;
    wait_reset();

    // known contents everywhere, derived from the byte address
    for (int i = 0; i < 2**RAM_AW; i++) begin
      a = 32'(i) << 2;
      d = a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
      ram_store(SIZE_WORD, a, d);
      bus_write(SIZE_WORD, a, d);
    end

    for (int i = 0; i < 60; i++) begin
      a = next_rand() & 32'h03FF_FFFC;
      d = next_rand();
      ram_store(SIZE_WORD, a, d);
      bus_write(SIZE_WORD, a, d);
      r = a ^ (next_rand() & ALIAS_BITS);
      bus_read(SIZE_WORD, r, ram_load(SIZE_WORD, r));
      r = next_rand() & 32'h03FF_FFFC;
      bus_read(SIZE_WORD, r, ram_load(SIZE_WORD, r));
    end
    idle(1);
    u_mon.end_test("ram_word");

    for (int i = 0; i < 80; i++) begin
      r  = next_rand();
      sz = r[3] ? SIZE_HALF : SIZE_BYTE;
      a  = next_rand() & 32'h03FF_FFFF;
      if (sz == SIZE_HALF) begin
        a[0] = 1'b0;
      end
      d = next_rand();
      ram_store(sz, a, d);
      bus_write(sz, a, d);
      bus_read(sz, a, ram_load(sz, a));
      bus_read(SIZE_WORD, a, ram_load(SIZE_WORD, a));
    end
    idle(1);
    u_mon.end_test("ram_sub");

    for (int t = 0; t < 2; t++) begin
      base = TMR_BASE | (32'(t) << 12);
      d    = 32'd5 + (next_rand() & 32'hF);
      bus_write(SIZE_WORD, base + 32'h4, d);
      bus_read(SIZE_WORD, base + 32'h4, d);
      idle(int'(d) + 3);
      bus_read(SIZE_WORD, base, 32'h1);
      check_irq(2'b00);
      bus_write(SIZE_WORD, base, 32'h2);
      idle(int'(d) + 3);
      check_irq(2'b01 << t);
      // reload first so no expiry lands between clear and read
      bus_write(SIZE_WORD, base + 32'h4, d);
      bus_write(SIZE_WORD, base, 32'h0);
      bus_read(SIZE_WORD, base, 32'h0);
      check_irq(2'b00);
    end
    u_mon.end_test("timer");

    for (int i = 0; i < 12; i++) begin
      d = next_rand();
      bus_write(SIZE_WORD, BIO_BASE, d);
      idle(1);
      u_mon.compare("o_led", d & ((32'h1 << NUM_LED) - 32'h1), 32'(led));
      sw = NUM_SW'(next_rand());
      bus_read(SIZE_WORD, BIO_BASE, d & ((32'h1 << NUM_LED) - 32'h1));
      idle(4);
      bus_read(SIZE_WORD, BIO_BASE + 32'h4, 32'(sw));
    end
    idle(1);
    u_mon.end_test("board_io");

    @(negedge clk);
    cpu_en   = 1'b1;
    cpu_wr   = 1'b0;
    cpu_size = SIZE_WORD;
    cpu_addr = 32'h2000_0000;
    chk      = 1'b0;
    repeat (20) begin
      @(posedge clk);
      u_mon.compare("o_cpu_wt", 32'h1, {31'h0, cpu_wt});
    end
    idle(1);
    a = next_rand() & 32'h03FF_FFFC;
    bus_read(SIZE_WORD, a, ram_load(SIZE_WORD, a));
    idle(1);
    u_mon.end_test("unmapped");

    u_mon.summary(i_dut.u_chk.fail_cnt);
    if (u_mon.n_err == 0 && i_dut.u_chk.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hw/bus_pkg.sv
hw/bus_if.sv
hw/bus_decode.sv
hw/ram_dev.sv
hw/tmr_dev.sv
hw/bio_dev.sv
hw/bus_result.sv
hw/bus_top.sv
dv/tb_clk.sv
dv/bus_checker.sv
dv/tb_monitor.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# compiles the board bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_top +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
